// ==== include/dispatch_config.svh ====
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// instruction word width
`define WORD_W 32

// architectural register counts
`define S_REGS 32
`define M_REGS 16

// producer tag width where zero means the value is ready
`define TAG_W 2

// scalar alu, scalar ld/st, branch, matrix ld/st, gemm
`define N_FU 5

`endif

// ==== hdl/dispatch_pkg.sv ====
`default_nettype none

`include "dispatch_config.svh"

package dispatch_pkg;

    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111,
        OP_HALT   = 7'b1111111
    } opcode_t;

    // unit codes double as bit positions in fu_busy / fu_done
    typedef enum logic [2:0] {
        FU_S_ALU    = 3'd0,
        FU_S_LD_ST  = 3'd1,
        FU_S_BRANCH = 3'd2,
        FU_M_LD_ST  = 3'd3,
        FU_GEMM     = 3'd4,
        FU_NONE     = 3'd7
    } fu_t;

    typedef logic [`TAG_W-1:0] tag_t;

    typedef logic [$clog2(`S_REGS)-1:0] sreg_t;
    typedef logic [$clog2(`M_REGS)-1:0] mreg_t;

    // scalar and matrix tables number their producers separately
    localparam tag_t TAG_READY  = `TAG_W'd0;
    localparam tag_t TAG_S_ALU  = `TAG_W'd1;
    localparam tag_t TAG_S_LOAD = `TAG_W'd2;
    localparam tag_t TAG_S_JUMP = `TAG_W'd3;
    localparam tag_t TAG_M_GEMM = `TAG_W'd1;
    localparam tag_t TAG_M_LOAD = `TAG_W'd2;

    typedef struct packed {
        logic [6:0] funct7;
        sreg_t      rs2;
        sreg_t      rs1;
        logic [2:0] funct3;
        sreg_t      rd;
        opcode_t    opcode;
    } s_view_t;

    // off is the signed address offset of a matrix load/store
    typedef struct packed {
        mreg_t      md;
        mreg_t      ms1;
        mreg_t      ms2;
        mreg_t      ms3;
        logic [8:0] off;
        opcode_t    opcode;
    } m_view_t;

    typedef union packed {
        s_view_t s;
        m_view_t m;
    } instr_u;

    typedef struct packed {
        fu_t         fu;
        sreg_t       rd;
        sreg_t       rs1;
        sreg_t       rs2;
        mreg_t       ms3;
        logic [11:0] imm;
        tag_t        t1;
        tag_t        t2;
        tag_t        t3;
        logic        spec;
        logic        halt;
    } issue_t;

endpackage

`default_nettype wire

// ==== hdl/reg_status_if.sv ====
`default_nettype none

interface reg_status_if #(
    parameter int SEL_W = 5
);
    import dispatch_pkg::*;

    // destination marking at dispatch
    logic             di_write;
    logic [SEL_W-1:0] di_sel;
    tag_t             di_tag;
    logic             di_spec;

    // clear on writeback
    logic             wb_write;
    logic [SEL_W-1:0] wb_sel;

    // drop speculative entries
    logic             flush;

    // source lookups
    logic [SEL_W-1:0] rd_sel0;
    logic [SEL_W-1:0] rd_sel1;
    logic [SEL_W-1:0] rd_sel2;
    tag_t             rd_tag0;
    tag_t             rd_tag1;
    tag_t             rd_tag2;

    logic             dest_busy;

    modport stage (
        output di_write, di_sel, di_tag, di_spec, wb_write, wb_sel, flush,
        output rd_sel0, rd_sel1, rd_sel2,
        input  rd_tag0, rd_tag1, rd_tag2, dest_busy
    );

    modport tbl (
        input  di_write, di_sel, di_tag, di_spec, wb_write, wb_sel, flush,
        input  rd_sel0, rd_sel1, rd_sel2,
        output rd_tag0, rd_tag1, rd_tag2, dest_busy
    );

endinterface

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
    input  dispatch_pkg::instr_u instr,
    output dispatch_pkg::fu_t    fu,
    output logic                 s_reg_write,
    output logic                 m_reg_write,
    output logic                 is_branch,
    output logic                 is_jump,
    output logic                 halt,
    output logic [11:0]          imm,
    output dispatch_pkg::tag_t   s_tag,
    output dispatch_pkg::tag_t   m_tag
);
    import dispatch_pkg::*;

    always_comb begin
        fu          = FU_NONE;
        s_reg_write = 1'b0;
        m_reg_write = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        halt        = 1'b0;
        imm         = '0;
        s_tag       = TAG_READY;
        m_tag       = TAG_READY;

        case (instr.s.opcode)
            OP_ALU: begin
                fu          = FU_S_ALU;
                s_reg_write = 1'b1;
                s_tag       = TAG_S_ALU;
            end
            OP_ALUI: begin
                fu          = FU_S_ALU;
                s_reg_write = 1'b1;
                s_tag       = TAG_S_ALU;
                imm         = {instr.s.funct7, instr.s.rs2};
            end
            OP_LOAD: begin
                fu          = FU_S_LD_ST;
                s_reg_write = 1'b1;
                s_tag       = TAG_S_LOAD;
                imm         = {instr.s.funct7, instr.s.rs2};
            end
            OP_STORE: begin
                fu  = FU_S_LD_ST;
                // store offset is split around rs2
                imm = {instr.s.funct7, instr.s.rd};
            end
            OP_BRANCH: begin
                fu        = FU_S_BRANCH;
                is_branch = 1'b1;
                imm       = {instr.s.funct7[6], instr.s.rd[0],
                             instr.s.funct7[5:0], instr.s.rd[4:1]};
            end
            OP_JAL, OP_JALR: begin
                // link register is written by the branch unit
                fu          = FU_S_BRANCH;
                is_jump     = 1'b1;
                s_reg_write = 1'b1;
                s_tag       = TAG_S_JUMP;
                imm         = {instr.s.funct7, instr.s.rs2};
            end
            OP_MLOAD: begin
                fu          = FU_M_LD_ST;
                m_reg_write = 1'b1;
                m_tag       = TAG_M_LOAD;
                imm         = {{3{instr.m.off[8]}}, instr.m.off};
            end
            OP_MSTORE: begin
                fu  = FU_M_LD_ST;
                imm = {{3{instr.m.off[8]}}, instr.m.off};
            end
            OP_GEMM: begin
                fu          = FU_GEMM;
                m_reg_write = 1'b1;
                m_tag       = TAG_M_GEMM;
            end
            OP_HALT: begin
                halt = 1'b1;
            end
            default: begin
                // unknown opcode goes out as a no-op
                fu = FU_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/reg_status_table.sv ====
`default_nettype none

module reg_status_table #(
    parameter int NREGS = 32,
    parameter int SEL_W = 5
) (
    input  logic         CLK,
    input  logic         nRST,
    reg_status_if.tbl    rs
);
    import dispatch_pkg::*;

    logic [NREGS-1:0] busy;
    logic [NREGS-1:0] spec;
    tag_t             tags [NREGS];

    // a register cleared by writeback this cycle already reads as ready
    function automatic tag_t lookup(input logic [SEL_W-1:0] sel);
        tag_t t;
        t = tags[sel];
        if (!busy[sel] || (rs.wb_write && rs.wb_sel == sel)) begin
            t = TAG_READY;
        end
        return t;
    endfunction

    assign rs.rd_tag0 = lookup(rs.rd_sel0);
    assign rs.rd_tag1 = lookup(rs.rd_sel1);
    assign rs.rd_tag2 = lookup(rs.rd_sel2);

    // same bypass for the destination, so a freed register is taken at once
    assign rs.dest_busy = busy[rs.di_sel] && !(rs.wb_write && rs.wb_sel == rs.di_sel);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            spec <= '0;
        end else begin
            for (int i = 0; i < NREGS; i++) begin
                if ((rs.flush && spec[i]) || (rs.wb_write && rs.wb_sel == SEL_W'(i))) begin
                    busy[i] <= 1'b0;
                    spec[i] <= 1'b0;
                end
            end
            // dispatch write comes last and wins over a clear
            if (rs.di_write) begin
                busy[rs.di_sel] <= 1'b1;
                spec[rs.di_sel] <= rs.di_spec;
            end
        end
    end

    // producer of each pending register
    always_ff @(posedge CLK) begin
        if (rs.di_write) begin
            tags[rs.di_sel] <= rs.di_tag;
        end
    end

    // the stage must honour the WAW check before marking a destination
    a_no_double_mark: assert property (
        @(posedge CLK) disable iff (!nRST)
        rs.di_write |-> !rs.dest_busy
    );

endmodule

`default_nettype wire

// ==== hdl/dispatch_stage.sv ====
`default_nettype none

`include "dispatch_config.svh"

module dispatch_stage (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dispatch_pkg::instr_u instr,
    input  logic                 instr_valid,
    input  dispatch_pkg::fu_t    fu,
    input  logic                 s_reg_write,
    input  logic                 m_reg_write,
    input  logic                 is_branch,
    input  logic                 is_jump,
    input  logic                 halt,
    input  logic [11:0]          imm,
    input  dispatch_pkg::tag_t   s_tag,
    input  dispatch_pkg::tag_t   m_tag,
    input  logic [`N_FU-1:0]     fu_busy,
    input  logic [`N_FU-1:0]     fu_done,
    input  logic                 wb_s_en,
    input  dispatch_pkg::sreg_t  wb_s_sel,
    input  logic                 wb_m_en,
    input  dispatch_pkg::mreg_t  wb_m_sel,
    input  logic                 branch_resolved,
    input  logic                 branch_miss,
    output logic                 freeze,
    output logic                 jump,
    output logic                 spec_out,
    output logic                 issue_valid,
    output dispatch_pkg::issue_t issue,
    reg_status_if.stage          s_rs,
    reg_status_if.stage          m_rs
);
    import dispatch_pkg::*;

    logic   unit_busy;
    logic   waw;
    logic   accept;
    logic   m_store;
    sreg_t  s_base;
    logic   spec;
    logic   jump_q;
    issue_t rec;

    // matrix ld/st base register sits in bits 27:23
    assign s_base  = {instr.m.ms1, instr.m.ms2[3]};
    assign m_store = (fu == FU_M_LD_ST) && !m_reg_write;

    // structural hazard when the unit is busy and not retiring this cycle
    always_comb begin
        unit_busy = 1'b0;
        if (int'(fu) < `N_FU) begin
            unit_busy = fu_busy[fu] && !fu_done[fu];
        end
    end

    assign waw    = (s_reg_write && s_rs.dest_busy) || (m_reg_write && m_rs.dest_busy);
    assign freeze = instr_valid && (unit_busy || waw);
    assign accept = instr_valid && !freeze && !branch_miss;

    // destination marking
    assign s_rs.di_write = accept && s_reg_write;
    assign s_rs.di_sel   = instr.s.rd;
    assign s_rs.di_tag   = s_tag;
    assign s_rs.di_spec  = spec;
    assign m_rs.di_write = accept && m_reg_write;
    assign m_rs.di_sel   = instr.m.md;
    assign m_rs.di_tag   = m_tag;
    assign m_rs.di_spec  = spec;

    assign s_rs.wb_write = wb_s_en;
    assign s_rs.wb_sel   = wb_s_sel;
    assign m_rs.wb_write = wb_m_en;
    assign m_rs.wb_sel   = wb_m_sel;

    // only the scalar side is squashed on a miss
    assign s_rs.flush = branch_miss;
    assign m_rs.flush = 1'b0;

    // source lookups
    assign s_rs.rd_sel0 = (fu == FU_M_LD_ST) ? s_base : instr.s.rs1;
    assign s_rs.rd_sel1 = instr.s.rs2;
    // scalar ops have two sources at most
    assign s_rs.rd_sel2 = '0;
    assign m_rs.rd_sel0 = m_store ? instr.m.md : instr.m.ms1;
    assign m_rs.rd_sel1 = instr.m.ms2;
    assign m_rs.rd_sel2 = instr.m.ms3;

    always_comb begin
        rec      = '0;
        rec.fu   = fu;
        rec.imm  = imm;
        rec.ms3  = instr.m.ms3;
        rec.spec = spec;
        rec.halt = halt;
        case (fu)
            FU_M_LD_ST: begin
                rec.rd  = sreg_t'(instr.m.md);
                rec.rs1 = s_base;
                rec.rs2 = sreg_t'(instr.m.ms2);
                rec.t1  = s_rs.rd_tag0;
                // stored matrix is a source, loaded matrix is not
                rec.t2  = m_store ? m_rs.rd_tag0 : TAG_READY;
            end
            FU_GEMM: begin
                rec.rd  = sreg_t'(instr.m.md);
                rec.rs1 = sreg_t'(instr.m.ms1);
                rec.rs2 = sreg_t'(instr.m.ms2);
                rec.t1  = m_rs.rd_tag0;
                rec.t2  = m_rs.rd_tag1;
                rec.t3  = m_rs.rd_tag2;
            end
            default: begin
                rec.rd  = instr.s.rd;
                rec.rs1 = instr.s.rs1;
                rec.rs2 = instr.s.rs2;
                if (fu != FU_NONE) begin
                    rec.t1 = s_rs.rd_tag0;
                    rec.t2 = s_rs.rd_tag1;
                end
            end
        endcase
    end

    // speculation and jump flags where a set on the same edge wins
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec   <= 1'b0;
            jump_q <= 1'b0;
        end else begin
            if (accept && is_branch) begin
                spec <= 1'b1;
            end else if (branch_resolved || branch_miss) begin
                spec <= 1'b0;
            end
            if (accept && is_jump) begin
                jump_q <= 1'b1;
            end else if (fu_done[FU_S_BRANCH]) begin
                jump_q <= 1'b0;
            end
        end
    end

    assign spec_out = spec;
    assign jump     = jump_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            issue <= rec;
        end
    end

    // a miss only arrives while a conditional branch is outstanding
    a_miss_needs_spec: assert property (
        @(posedge CLK) disable iff (!nRST)
        branch_miss |-> spec
    );

    // fetch keeps a frozen word on offer
    a_frozen_word_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        freeze |=> instr_valid && $stable(instr)
    );

endmodule

`default_nettype wire

// ==== hdl/dispatch_top.sv ====
`default_nettype none

`include "dispatch_config.svh"

module dispatch_top (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [`WORD_W-1:0]          instr,
    input  logic                        instr_valid,
    input  logic [`N_FU-1:0]            fu_busy,
    input  logic [`N_FU-1:0]            fu_done,
    input  logic                        wb_s_en,
    input  logic [$clog2(`S_REGS)-1:0]  wb_s_sel,
    input  logic                        wb_m_en,
    input  logic [$clog2(`M_REGS)-1:0]  wb_m_sel,
    input  logic                        branch_resolved,
    input  logic                        branch_miss,
    output logic                        freeze,
    output logic                        jump,
    output logic                        spec_out,
    output logic                        issue_valid,
    output logic [2:0]                  issue_fu,
    output logic [$clog2(`S_REGS)-1:0]  issue_rd,
    output logic [$clog2(`S_REGS)-1:0]  issue_rs1,
    output logic [$clog2(`S_REGS)-1:0]  issue_rs2,
    output logic [$clog2(`M_REGS)-1:0]  issue_ms3,
    output logic [11:0]                 issue_imm,
    output logic [`TAG_W-1:0]           issue_t1,
    output logic [`TAG_W-1:0]           issue_t2,
    output logic [`TAG_W-1:0]           issue_t3,
    output logic                        issue_spec,
    output logic                        issue_halt
);
    import dispatch_pkg::*;

    instr_u      instr_w;
    fu_t         fu;
    logic        s_reg_write;
    logic        m_reg_write;
    logic        is_branch;
    logic        is_jump;
    logic        halt;
    logic [11:0] imm;
    tag_t        s_tag;
    tag_t        m_tag;
    issue_t      issue;

    reg_status_if #(.SEL_W($clog2(`S_REGS))) s_rs ();
    reg_status_if #(.SEL_W($clog2(`M_REGS))) m_rs ();

    assign instr_w = instr;

    instr_decoder u_dec (
        .instr       (instr_w),
        .fu          (fu),
        .s_reg_write (s_reg_write),
        .m_reg_write (m_reg_write),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .halt        (halt),
        .imm         (imm),
        .s_tag       (s_tag),
        .m_tag       (m_tag)
    );

    dispatch_stage u_stage (
        .CLK             (CLK),
        .nRST            (nRST),
        .instr           (instr_w),
        .instr_valid     (instr_valid),
        .fu              (fu),
        .s_reg_write     (s_reg_write),
        .m_reg_write     (m_reg_write),
        .is_branch       (is_branch),
        .is_jump         (is_jump),
        .halt            (halt),
        .imm             (imm),
        .s_tag           (s_tag),
        .m_tag           (m_tag),
        .fu_busy         (fu_busy),
        .fu_done         (fu_done),
        .wb_s_en         (wb_s_en),
        .wb_s_sel        (wb_s_sel),
        .wb_m_en         (wb_m_en),
        .wb_m_sel        (wb_m_sel),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .freeze          (freeze),
        .jump            (jump),
        .spec_out        (spec_out),
        .issue_valid     (issue_valid),
        .issue           (issue),
        .s_rs            (s_rs),
        .m_rs            (m_rs)
    );

    reg_status_table #(.NREGS(`S_REGS), .SEL_W($clog2(`S_REGS))) u_s_table (
        .CLK  (CLK),
        .nRST (nRST),
        .rs   (s_rs)
    );

    reg_status_table #(.NREGS(`M_REGS), .SEL_W($clog2(`M_REGS))) u_m_table (
        .CLK  (CLK),
        .nRST (nRST),
        .rs   (m_rs)
    );

    // flatten the issue record
    assign issue_fu   = issue.fu;
    assign issue_rd   = issue.rd;
    assign issue_rs1  = issue.rs1;
    assign issue_rs2  = issue.rs2;
    assign issue_ms3  = issue.ms3;
    assign issue_imm  = issue.imm;
    assign issue_t1   = issue.t1;
    assign issue_t2   = issue.t2;
    assign issue_t3   = issue.t3;
    assign issue_spec = issue.spec;
    assign issue_halt = issue.halt;

endmodule

`default_nettype wire

// ==== verification/dispatch_tb.sv ====
`default_nettype none

`include "dispatch_config.svh"

module dispatch_tb;
    import dispatch_pkg::*;

    localparam int N_CYCLES  = 4000;
    localparam int STALL_MAX = 200;
    localparam opcode_t OP_LIST [11] = '{OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH,
        OP_JAL, OP_JALR, OP_MLOAD, OP_MSTORE, OP_GEMM, OP_HALT};

    logic              CLK;
    logic              nRST;
    logic [31:0]       instr;
    logic              instr_valid;
    logic [`N_FU-1:0]  fu_busy;
    logic [`N_FU-1:0]  fu_done;
    logic              wb_s_en;
    logic [4:0]        wb_s_sel;
    logic              wb_m_en;
    logic [3:0]        wb_m_sel;
    logic              branch_resolved;
    logic              branch_miss;
    logic              freeze;
    logic              jump;
    logic              spec_out;
    logic              issue_valid;
    logic [2:0]        issue_fu;
    logic [4:0]        issue_rd;
    logic [4:0]        issue_rs1;
    logic [4:0]        issue_rs2;
    logic [3:0]        issue_ms3;
    logic [11:0]       issue_imm;
    logic [1:0]        issue_t1;
    logic [1:0]        issue_t2;
    logic [1:0]        issue_t3;
    logic              issue_spec;
    logic              issue_halt;

    // reference model state
    logic [31:0] s_busy;
    logic [31:0] s_spec;
    logic [1:0]  s_tag [32];
    logic [15:0] m_busy;
    logic [1:0]  m_tag [16];
    logic        spec_m;
    logic        jump_m;
    logic        exp_valid;
    issue_t      exp_rec;
    issue_t      cand_rec;

    // decoded view of the current word
    fu_t         d_fu;
    logic        d_swr;
    logic        d_mwr;
    logic        d_br;
    logic        d_jmp;
    logic        d_halt;
    logic [11:0] d_imm;
    logic [1:0]  d_stag;
    logic [1:0]  d_mtag;

    integer seed;
    int     errors;
    int     checks;
    int     issued;
    int     frozen;
    int     stall;
    logic   hold;
    logic   timed_out;
    logic   exp_freeze;
    logic   acc;

    dispatch_top uut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // pending unless written back in this same cycle
    function automatic logic s_pending(input logic [4:0] r);
        return s_busy[r] && !(wb_s_en && wb_s_sel == r);
    endfunction

    function automatic logic m_pending(input logic [3:0] r);
        return m_busy[r] && !(wb_m_en && wb_m_sel == r);
    endfunction

    function automatic logic [1:0] s_read(input logic [4:0] r);
        return s_pending(r) ? s_tag[r] : 2'd0;
    endfunction

    function automatic logic [1:0] m_read(input logic [3:0] r);
        return m_pending(r) ? m_tag[r] : 2'd0;
    endfunction

    task automatic decode_model(input logic [31:0] w);
        case (w[6:0])
            OP_ALU, OP_ALUI: d_fu = FU_S_ALU;
            OP_LOAD, OP_STORE: d_fu = FU_S_LD_ST;
            OP_BRANCH, OP_JAL, OP_JALR: d_fu = FU_S_BRANCH;
            OP_MLOAD, OP_MSTORE: d_fu = FU_M_LD_ST;
            OP_GEMM: d_fu = FU_GEMM;
            default: d_fu = FU_NONE;
        endcase
        d_br   = w[6:0] == OP_BRANCH;
        d_jmp  = w[6:0] == OP_JAL || w[6:0] == OP_JALR;
        d_halt = w[6:0] == OP_HALT;
        d_swr  = d_fu == FU_S_ALU || w[6:0] == OP_LOAD || d_jmp;
        d_mwr  = w[6:0] == OP_MLOAD || w[6:0] == OP_GEMM;
        d_stag = d_jmp ? 2'd3 : (w[6:0] == OP_LOAD ? 2'd2 : 2'd1);
        d_mtag = w[6:0] == OP_MLOAD ? 2'd2 : 2'd1;
        case (w[6:0])
            OP_ALUI, OP_LOAD, OP_JAL, OP_JALR: d_imm = w[31:20];
            OP_STORE: d_imm = {w[31:25], w[11:7]};
            OP_BRANCH: d_imm = {w[31], w[7], w[30:25], w[11:8]};
            OP_MLOAD, OP_MSTORE: d_imm = {{3{w[15]}}, w[15:7]};
            default: d_imm = 12'd0;
        endcase
    endtask

    task automatic predict_record();
        cand_rec      = '0;
        cand_rec.fu   = d_fu;
        cand_rec.imm  = d_imm;
        cand_rec.ms3  = instr[19:16];
        cand_rec.spec = spec_m;
        cand_rec.halt = d_halt;
        if (d_fu == FU_M_LD_ST) begin
            cand_rec.rd  = {1'b0, instr[31:28]};
            cand_rec.rs1 = instr[27:23];
            cand_rec.rs2 = {1'b0, instr[23:20]};
            cand_rec.t1  = s_read(instr[27:23]);
            // a matrix store reads md as its data source
            cand_rec.t2  = d_mwr ? 2'd0 : m_read(instr[31:28]);
        end else if (d_fu == FU_GEMM) begin
            cand_rec.rd  = {1'b0, instr[31:28]};
            cand_rec.rs1 = {1'b0, instr[27:24]};
            cand_rec.rs2 = {1'b0, instr[23:20]};
            cand_rec.t1  = m_read(instr[27:24]);
            cand_rec.t2  = m_read(instr[23:20]);
            cand_rec.t3  = m_read(instr[19:16]);
        end else begin
            cand_rec.rd  = instr[11:7];
            cand_rec.rs1 = instr[19:15];
            cand_rec.rs2 = instr[24:20];
            if (d_fu != FU_NONE) begin
                cand_rec.t1 = s_read(instr[19:15]);
                cand_rec.t2 = s_read(instr[24:20]);
            end
        end
    endtask

    task automatic advance_model();
        for (int i = 0; i < 32; i++) begin
            if ((branch_miss && s_spec[i]) || (wb_s_en && wb_s_sel == 5'(i))) begin
                s_busy[i] = 1'b0;
                s_spec[i] = 1'b0;
            end
        end
        if (wb_m_en) begin
            m_busy[wb_m_sel] = 1'b0;
        end
        if (acc && d_swr) begin
            s_busy[instr[11:7]] = 1'b1;
            s_spec[instr[11:7]] = spec_m;
            s_tag[instr[11:7]]  = d_stag;
        end
        if (acc && d_mwr) begin
            m_busy[instr[31:28]] = 1'b1;
            m_tag[instr[31:28]]  = d_mtag;
        end
        if (acc && d_br) begin
            spec_m = 1'b1;
        end else if (branch_resolved || branch_miss) begin
            spec_m = 1'b0;
        end
        if (acc && d_jmp) begin
            jump_m = 1'b1;
        end else if (fu_done[FU_S_BRANCH]) begin
            jump_m = 1'b0;
        end
        exp_valid = acc;
        if (acc) begin
            exp_rec = cand_rec;
        end
        // fetch keeps offering a word that was not taken
        hold = instr_valid && !acc;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] w;
        logic [4:0]  idx;
        logic [4:0]  sj;
        logic [3:0]  mj;
        logic        found;
        r  = $random(seed);
        r2 = $random(seed);
        if (!hold) begin
            w   = $random(seed);
            idx = r[4:0] % 5'd12;
            // index 11 stands for an opcode the decoder does not know
            instr       = {w[31:7], (idx < 5'd11) ? OP_LIST[idx[3:0]] : 7'h0b};
            instr_valid = r[7:5] != 3'd0;
        end
        fu_busy         = r[12:8] & r[17:13];
        fu_done         = r[22:18] & r[27:23];
        branch_miss     = spec_m && r2[3:0] == 4'd0;
        branch_resolved = spec_m && !branch_miss && r2[6:4] == 3'd0;
        // write back some pending register, searched from a random start
        found    = 1'b0;
        wb_s_sel = r2[11:7];
        for (int i = 0; i < 32; i++) begin
            sj = r2[11:7] + 5'(i);
            if (!found && s_busy[sj]) begin
                found    = 1'b1;
                wb_s_sel = sj;
            end
        end
        wb_s_en  = found && r2[14:13] != 2'd0;
        found    = 1'b0;
        wb_m_sel = r2[18:15];
        for (int i = 0; i < 16; i++) begin
            mj = r2[18:15] + 4'(i);
            if (!found && m_busy[mj]) begin
                found    = 1'b1;
                wb_m_sel = mj;
            end
        end
        wb_m_en = found && r2[20:19] != 2'd0;
    endtask

    task automatic check_outputs();
        check_value("issue_valid", 32'(issue_valid), 32'(exp_valid));
        check_value("spec_out", 32'(spec_out), 32'(spec_m));
        check_value("jump", 32'(jump), 32'(jump_m));
        if (exp_valid) begin
            issued++;
            check_value("issue_fu", 32'(issue_fu), 32'(exp_rec.fu));
            check_value("issue_rd", 32'(issue_rd), 32'(exp_rec.rd));
            check_value("issue_rs1", 32'(issue_rs1), 32'(exp_rec.rs1));
            check_value("issue_rs2", 32'(issue_rs2), 32'(exp_rec.rs2));
            check_value("issue_ms3", 32'(issue_ms3), 32'(exp_rec.ms3));
            check_value("issue_imm", 32'(issue_imm), 32'(exp_rec.imm));
            check_value("issue_t1", 32'(issue_t1), 32'(exp_rec.t1));
            check_value("issue_t2", 32'(issue_t2), 32'(exp_rec.t2));
            check_value("issue_t3", 32'(issue_t3), 32'(exp_rec.t3));
            check_value("issue_spec", 32'(issue_spec), 32'(exp_rec.spec));
            check_value("issue_halt", 32'(issue_halt), 32'(exp_rec.halt));
        end
    endtask

    initial begin
        seed            = 32'hae6f988b;
        errors          = 0;
        checks          = 0;
        issued          = 0;
        frozen          = 0;
        stall           = 0;
        hold            = 1'b0;
        timed_out       = 1'b0;
        nRST            = 1'b0;
        instr           = '0;
        instr_valid     = 1'b0;
        fu_busy         = '0;
        fu_done         = '0;
        wb_s_en         = 1'b0;
        wb_s_sel        = '0;
        wb_m_en         = 1'b0;
        wb_m_sel        = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        s_busy          = '0;
        s_spec          = '0;
        m_busy          = '0;
        spec_m          = 1'b0;
        jump_m          = 1'b0;
        exp_valid       = 1'b0;
        exp_rec         = '0;

        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;
        check_value("freeze after reset", 32'(freeze), 32'd0);

        for (int cyc = 0; cyc < N_CYCLES && !timed_out; cyc++) begin
            @(posedge CLK);
            #1;
            check_outputs();
            drive_inputs();
            #1;
            decode_model(instr);
            predict_record();
            exp_freeze = instr_valid && ((d_fu != FU_NONE && fu_busy[d_fu] && !fu_done[d_fu])
                || (d_swr && s_pending(instr[11:7])) || (d_mwr && m_pending(instr[31:28])));
            check_value("freeze", 32'(freeze), 32'(exp_freeze));
            frozen += int'(exp_freeze);
            acc = instr_valid && !exp_freeze && !branch_miss;
            advance_model();
            stall = hold ? stall + 1 : 0;
            if (stall > STALL_MAX) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: an instruction was held for %0d cycles without issue", stall);
            end
        end

        $display("checks %0d, errors %0d, issued %0d, frozen cycles %0d",
                 checks, errors, issued, frozen);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hdl/dispatch_pkg.sv
hdl/reg_status_if.sv
hdl/instr_decoder.sv
hdl/reg_status_table.sv
hdl/dispatch_stage.sv
hdl/dispatch_top.sv
verification/dispatch_tb.sv

// ==== Makefile ====
# Verilator simulation of the dispatch stage

VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
